/* filelist.f */
src/regfile_pkg.sv
src/regfile_if.sv
src/register_file.sv
src/access_arbiter.sv
src/cmd_engine.sv
src/regfile_subsystem.sv
tests/regfile_assertions.sv
tests/tb_regfile_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the register file subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_regfile_subsystem -f filelist.f -o sim_regfile
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# a failing assertion must not stop the run before the testbench reports it
./obj_dir/sim_regfile +verilator+error+limit+100 > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

/* tests/regfile_vectors.txt */
// columns are ch op dst src0 src1 data expected in hex, op 0 write 1 read 2 add
// ch 2 waits until both channels are idle and its op column switches random gaps on or off
0 1 0 0 0 00 00
0 1 0 1 0 00 00
0 1 0 2 0 00 00
0 1 0 3 0 00 00
0 1 0 4 0 00 00
0 1 0 5 0 00 00
0 1 0 6 0 00 00
0 1 0 7 0 00 00
1 1 0 0 0 00 00
1 1 0 1 0 00 00
1 1 0 2 0 00 00
1 1 0 3 0 00 00
1 1 0 4 0 00 00
1 1 0 5 0 00 00
1 1 0 6 0 00 00
1 1 0 7 0 00 00
2 1 0 0 0 00 00
0 0 0 0 0 2a 00
1 0 4 0 0 2e 00
0 0 1 0 0 2b 00
1 0 5 0 0 2f 00
0 0 2 0 0 2c 00
1 0 6 0 0 30 00
0 0 3 0 0 2d 00
1 0 7 0 0 31 00
0 1 0 0 0 00 2a
1 1 0 4 0 00 2e
0 1 0 1 0 00 2b
1 1 0 5 0 00 2f
0 1 0 2 0 00 2c
1 1 0 6 0 00 30
0 1 0 3 0 00 2d
1 1 0 7 0 00 31
0 2 0 0 1 00 55
1 0 7 0 0 f0 00
0 1 0 0 0 00 55
1 2 4 7 5 00 1f
0 2 2 2 2 00 58
1 1 0 4 0 00 1f
0 1 0 2 0 00 58

/* tests/tb_regfile_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_regfile_subsystem;

    localparam int max_vectors  = 64;
    localparam int fields       = 7;   // ch op dst src0 src1 data expected
    localparam int drain_cycles = 4 * regfile_pkg::cmd_depth;   // pops at least every other cycle
    localparam regfile_pkg::queue_count_t full_credits =
        regfile_pkg::queue_count_t'(regfile_pkg::cmd_depth);

    logic                   clk;
    logic                   arst_n;
    logic [1:0]             cmd_valid;
    regfile_pkg::cmd_op_t   cmd_op [2];
    regfile_pkg::reg_addr_t cmd_dst [2];
    regfile_pkg::reg_addr_t cmd_src0 [2];
    regfile_pkg::reg_addr_t cmd_src1 [2];
    regfile_pkg::reg_data_t cmd_data [2];
    logic [1:0]             cmd_credit;
    logic [1:0]             resp_valid;
    regfile_pkg::reg_data_t resp_data [2];

    logic [7:0]                vec_mem [fields*max_vectors];
    int                        num_vectors;
    logic [15:0]               lfsr;
    logic                      gaps_on;
    regfile_pkg::queue_count_t credits [2];
    regfile_pkg::reg_data_t    exp_q [2][$];

    regfile_subsystem dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .ch0_cmd_valid  (cmd_valid[0]),
        .ch0_cmd_op     (cmd_op[0]),
        .ch0_cmd_dst    (cmd_dst[0]),
        .ch0_cmd_src0   (cmd_src0[0]),
        .ch0_cmd_src1   (cmd_src1[0]),
        .ch0_cmd_data   (cmd_data[0]),
        .ch0_cmd_credit (cmd_credit[0]),
        .ch0_resp_valid (resp_valid[0]),
        .ch0_resp_data  (resp_data[0]),
        .ch1_cmd_valid  (cmd_valid[1]),
        .ch1_cmd_op     (cmd_op[1]),
        .ch1_cmd_dst    (cmd_dst[1]),
        .ch1_cmd_src0   (cmd_src0[1]),
        .ch1_cmd_src1   (cmd_src1[1]),
        .ch1_cmd_data   (cmd_data[1]),
        .ch1_cmd_credit (cmd_credit[1]),
        .ch1_resp_valid (resp_valid[1]),
        .ch1_resp_data  (resp_data[1])
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    function automatic int assertion_failures();
        return int'(dut.arbiter.arb_checks.failures + dut.engine0.eng_checks.failures +
                    dut.engine1.eng_checks.failures);
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input int ch, input regfile_pkg::reg_data_t got,
                              input regfile_pkg::reg_data_t want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH at %0t: channel %0d response %h, expected %h",
                               $time, ch, got, want));
        end
    endtask

    task automatic check_credit_count(input int ch, input regfile_pkg::queue_count_t got,
                                      input regfile_pkg::queue_count_t want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH at %0t: channel %0d holds %0d credits, expected %0d",
                               $time, ch, got, want));
        end
    endtask

    task automatic insert_gap();
        int cycles;
        cycles = 0;
        repeat (2) begin
            lfsr   = lfsr_step(lfsr);
            cycles = 2 * cycles + int'(lfsr[0]);
        end
        repeat (cycles) @(negedge clk);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((credits[0] != full_credits || credits[1] != full_credits ||
                exp_q[0].size() != 0 || exp_q[1].size() != 0) && cycles < drain_cycles) begin
            @(negedge clk);
            cycles++;
        end
        repeat (2) @(negedge clk);   // room for a stray credit or response
        for (int c = 0; c < 2; c++) begin
            if (exp_q[c].size() != 0) begin
                fail_run($sformatf("channel %0d still owes %0d responses", c, exp_q[c].size()));
            end
            check_credit_count(c, credits[c], full_credits);
        end
    endtask

    task automatic run_vector(input int v);
        logic [7:0] f [fields];
        int         ch;
        for (int i = 0; i < fields; i++) begin
            f[i] = vec_mem[fields*v+i];
        end
        ch = int'(f[0]);
        if (ch == 2) begin
            wait_idle();
            gaps_on = f[1][0];
        end else begin
            if (gaps_on) begin
                insert_gap();
            end
            while (credits[ch] == '0) begin
                @(negedge clk);
            end
            cmd_valid[ch] = 1'b1;
            cmd_op[ch]    = regfile_pkg::cmd_op_t'(f[1][1:0]);
            cmd_dst[ch]   = f[2][2:0];
            cmd_src0[ch]  = f[3][2:0];
            cmd_src1[ch]  = f[4][2:0];
            cmd_data[ch]  = f[5];
            credits[ch]   = credits[ch] - 1'b1;
            if (cmd_op[ch] != regfile_pkg::op_write) begin
                exp_q[ch].push_back(f[6]);
            end
            @(negedge clk);
            cmd_valid[ch] = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // outputs are registered, so the values seen here held for the whole cycle
    always @(posedge clk) begin
        if (arst_n) begin
            for (int c = 0; c < 2; c++) begin
                if (cmd_credit[c]) begin
                    if (credits[c] == full_credits) begin
                        fail_run($sformatf("channel %0d returned a credit it did not owe", c));
                    end
                    credits[c] = credits[c] + 1'b1;
                end
                if (resp_valid[c]) begin
                    if (exp_q[c].size() == 0) begin
                        fail_run($sformatf("channel %0d sent a response nobody asked for", c));
                    end
                    check_data(c, resp_data[c], exp_q[c].pop_front());
                end
            end
            if (assertion_failures() != 0) begin
                fail_run("a design assertion failed");
            end
        end
    end

    initial begin
        wait (num_vectors > 0);
        repeat (num_vectors * 20) @(posedge clk);
        fail_run($sformatf("timeout: vectors not finished after %0d cycles", num_vectors * 20));
    end

    initial begin
        int n;
        arst_n    = 1'b0;
        cmd_valid = '0;
        for (int c = 0; c < 2; c++) begin
            cmd_op[c]   = regfile_pkg::op_write;
            cmd_dst[c]  = '0;
            cmd_src0[c] = '0;
            cmd_src1[c] = '0;
            cmd_data[c] = '0;
            credits[c]  = full_credits;
        end
        lfsr    = 16'd57435;
        gaps_on = 1'b0;
        for (int i = 0; i < fields * max_vectors; i++) begin
            vec_mem[i] = 8'hff;   // channel ff marks the end
        end
        $readmemh("tests/regfile_vectors.txt", vec_mem);
        n = 0;
        while (n < max_vectors && vec_mem[fields*n] != 8'hff) begin
            n++;
        end
        if (n == 0) begin
            fail_run("no vectors found in tests/regfile_vectors.txt");
        end
        num_vectors = n;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int v = 0; v < num_vectors; v++) begin
            run_vector(v);
        end
        wait_idle();
        if (assertion_failures() != 0) begin
            fail_run("a design assertion failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/regfile_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_assertions (
    input wire logic                                 clk,
    input wire logic                                 arst_n,
    input wire logic [regfile_pkg::num_engines-1:0] req,
    input wire logic [regfile_pkg::num_engines-1:0] gnt,
    input wire logic                                 cmd_valid,
    input wire regfile_pkg::cmd_op_t                 head_op,
    input wire regfile_pkg::queue_count_t            count,
    input wire logic                                 resp_valid
);

    int unsigned failures = 0;   // polled by the testbench monitor

    function automatic void note_failure(input string what);
        failures++;
        $error("%s", what);
    endfunction

    gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(gnt))
        else note_failure("more than one grant in a cycle");

    gnt_needs_req: assert property (@(posedge clk) disable iff (!arst_n) (gnt & ~req) == '0)
        else note_failure("grant given to an engine without a request");

    // response only one cycle after a granted read or add
    resp_after_gnt: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> $past(gnt[0] && (head_op != regfile_pkg::op_write)))
        else note_failure("response without a granted read or add");

    no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_valid |-> count < regfile_pkg::queue_count_t'(regfile_pkg::cmd_depth))
        else note_failure("command accepted into a full queue");

endmodule

// arbiter instance has no queue or response so those inputs are tied off
bind access_arbiter regfile_assertions arb_checks (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .gnt        (gnt),
    .cmd_valid  (1'b0),
    .head_op    (regfile_pkg::op_write),
    .count      ('0),
    .resp_valid (1'b0)
);

bind cmd_engine regfile_assertions eng_checks (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        ({1'b0, req}),
    .gnt        ({1'b0, gnt}),
    .cmd_valid  (cmd_valid),
    .head_op    (head_op),
    .count      (count),
    .resp_valid (resp_valid)
);

`default_nettype wire

/* src/regfile_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_subsystem (
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    input  wire logic                   ch0_cmd_valid,
    input  wire regfile_pkg::cmd_op_t   ch0_cmd_op,
    input  wire regfile_pkg::reg_addr_t ch0_cmd_dst,
    input  wire regfile_pkg::reg_addr_t ch0_cmd_src0,
    input  wire regfile_pkg::reg_addr_t ch0_cmd_src1,
    input  wire regfile_pkg::reg_data_t ch0_cmd_data,
    output logic                        ch0_cmd_credit,
    output logic                        ch0_resp_valid,
    output regfile_pkg::reg_data_t      ch0_resp_data,

    input  wire logic                   ch1_cmd_valid,
    input  wire regfile_pkg::cmd_op_t   ch1_cmd_op,
    input  wire regfile_pkg::reg_addr_t ch1_cmd_dst,
    input  wire regfile_pkg::reg_addr_t ch1_cmd_src0,
    input  wire regfile_pkg::reg_addr_t ch1_cmd_src1,
    input  wire regfile_pkg::reg_data_t ch1_cmd_data,
    output logic                        ch1_cmd_credit,
    output logic                        ch1_resp_valid,
    output regfile_pkg::reg_data_t      ch1_resp_data
);

    logic [regfile_pkg::num_engines-1:0] req;
    logic [regfile_pkg::num_engines-1:0] gnt;

    regfile_if eng0_bus ();
    regfile_if eng1_bus ();
    regfile_if mem_bus ();   // arbiter to storage

    cmd_engine engine0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (ch0_cmd_valid),
        .cmd_op     (ch0_cmd_op),
        .cmd_dst    (ch0_cmd_dst),
        .cmd_src0   (ch0_cmd_src0),
        .cmd_src1   (ch0_cmd_src1),
        .cmd_data   (ch0_cmd_data),
        .cmd_credit (ch0_cmd_credit),
        .resp_valid (ch0_resp_valid),
        .resp_data  (ch0_resp_data),
        .req        (req[0]),
        .gnt        (gnt[0]),
        .rf         (eng0_bus)
    );

    cmd_engine engine1 (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (ch1_cmd_valid),
        .cmd_op     (ch1_cmd_op),
        .cmd_dst    (ch1_cmd_dst),
        .cmd_src0   (ch1_cmd_src0),
        .cmd_src1   (ch1_cmd_src1),
        .cmd_data   (ch1_cmd_data),
        .cmd_credit (ch1_cmd_credit),
        .resp_valid (ch1_resp_valid),
        .resp_data  (ch1_resp_data),
        .req        (req[1]),
        .gnt        (gnt[1]),
        .rf         (eng1_bus)
    );

    access_arbiter arbiter (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .gnt     (gnt),
        .client0 (eng0_bus),
        .client1 (eng1_bus),
        .mem     (mem_bus)
    );

    register_file storage (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (mem_bus)
    );

endmodule

`default_nettype wire

/* src/cmd_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_engine (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   cmd_valid,
    input  wire regfile_pkg::cmd_op_t   cmd_op,
    input  wire regfile_pkg::reg_addr_t cmd_dst,
    input  wire regfile_pkg::reg_addr_t cmd_src0,
    input  wire regfile_pkg::reg_addr_t cmd_src1,
    input  wire regfile_pkg::reg_data_t cmd_data,
    output logic                        cmd_credit,
    output logic                        resp_valid,
    output regfile_pkg::reg_data_t      resp_data,
    output logic                        req,
    input  wire logic                   gnt,
    regfile_if.client                   rf
);

    // command queue storage
    regfile_pkg::cmd_op_t   q_op   [regfile_pkg::cmd_depth];
    regfile_pkg::reg_addr_t q_dst  [regfile_pkg::cmd_depth];
    regfile_pkg::reg_addr_t q_src0 [regfile_pkg::cmd_depth];
    regfile_pkg::reg_addr_t q_src1 [regfile_pkg::cmd_depth];
    regfile_pkg::reg_data_t q_data [regfile_pkg::cmd_depth];

    regfile_pkg::queue_ptr_t    wr_ptr;
    regfile_pkg::queue_ptr_t    rd_ptr;
    regfile_pkg::queue_count_t  count;
    regfile_pkg::engine_state_t state;

    regfile_pkg::cmd_op_t   head_op;
    regfile_pkg::reg_data_t sum;
    logic                   pop;

    assign head_op = q_op[rd_ptr];
    assign req     = (count != '0) && (state != regfile_pkg::respond);
    assign pop     = req && gnt;

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            q_op[wr_ptr]   <= cmd_op;
            q_dst[wr_ptr]  <= cmd_dst;
            q_src0[wr_ptr] <= cmd_src0;
            q_src1[wr_ptr] <= cmd_src1;
            q_data[wr_ptr] <= cmd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at cmd_depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= regfile_pkg::idle;
        end else begin
            case (state)
                regfile_pkg::idle: begin
                    if (pop) begin
                        state <= regfile_pkg::respond;
                    end else if (count != '0) begin
                        state <= regfile_pkg::request;
                    end
                end
                regfile_pkg::request: begin
                    if (pop) begin
                        state <= regfile_pkg::respond;
                    end
                end
                default: begin
                    // one bubble keeps gnt to a single cycle
                    state <= (count != '0) ? regfile_pkg::request : regfile_pkg::idle;
                end
            endcase
        end
    end

    // head command drives the ports; the arbiter forwards them only when granted
    assign rf.rd0_enable = req && (head_op != regfile_pkg::op_write);
    assign rf.rd0_addr   = q_src0[rd_ptr];
    assign rf.rd1_enable = req && (head_op == regfile_pkg::op_add);
    assign rf.rd1_addr   = q_src1[rd_ptr];
    assign rf.wr_enable  = req && (head_op != regfile_pkg::op_read);
    assign rf.wr_addr    = q_dst[rd_ptr];

    assign sum        = rf.rd0_data + rf.rd1_data;   // wraps mod 256
    assign rf.wr_data = (head_op == regfile_pkg::op_add) ? sum : q_data[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
            cmd_credit <= 1'b0;
        end else begin
            resp_valid <= pop && (head_op != regfile_pkg::op_write);
            cmd_credit <= pop;   // one credit per popped command
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            resp_data <= (head_op == regfile_pkg::op_add) ? sum : rf.rd0_data;
        end
    end

endmodule

`default_nettype wire

/* src/access_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module access_arbiter (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic [regfile_pkg::num_engines-1:0] req,
    output logic      [regfile_pkg::num_engines-1:0] gnt,
    regfile_if.server                                 client0,
    regfile_if.server                                 client1,
    regfile_if.client                                 mem
);

    logic ptr;   // engine that wins when both request

    always_comb begin
        gnt = '0;
        if (req[ptr]) begin
            gnt[ptr] = 1'b1;
        end else if (req[~ptr]) begin
            gnt[~ptr] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= 1'b0;
        end else if (|gnt) begin
            ptr <= gnt[0];   // hand priority to the other engine
        end
    end

    always_comb begin
        mem.rd0_enable = 1'b0;
        mem.rd0_addr   = '0;
        mem.rd1_enable = 1'b0;
        mem.rd1_addr   = '0;
        mem.wr_enable  = 1'b0;
        mem.wr_addr    = '0;
        mem.wr_data    = '0;
        if (gnt[0]) begin
            mem.rd0_enable = client0.rd0_enable;
            mem.rd0_addr   = client0.rd0_addr;
            mem.rd1_enable = client0.rd1_enable;
            mem.rd1_addr   = client0.rd1_addr;
            mem.wr_enable  = client0.wr_enable;
            mem.wr_addr    = client0.wr_addr;
            mem.wr_data    = client0.wr_data;
        end else if (gnt[1]) begin
            mem.rd0_enable = client1.rd0_enable;
            mem.rd0_addr   = client1.rd0_addr;
            mem.rd1_enable = client1.rd1_enable;
            mem.rd1_addr   = client1.rd1_addr;
            mem.wr_enable  = client1.wr_enable;
            mem.wr_addr    = client1.wr_addr;
            mem.wr_data    = client1.wr_data;
        end
    end

    assign client0.rd0_data = gnt[0] ? mem.rd0_data : '0;
    assign client0.rd1_data = gnt[0] ? mem.rd1_data : '0;
    assign client1.rd0_data = gnt[1] ? mem.rd0_data : '0;
    assign client1.rd1_data = gnt[1] ? mem.rd1_data : '0;

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic clk,
    input  wire logic arst_n,
    regfile_if.server bus
);

    regfile_pkg::reg_data_t regs [regfile_pkg::num_regs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < regfile_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.wr_enable) begin
            regs[bus.wr_addr] <= bus.wr_data;
        end
    end

    // reads see the value before this cycle's write
    assign bus.rd0_data = bus.rd0_enable ? regs[bus.rd0_addr] : '0;
    assign bus.rd1_data = bus.rd1_enable ? regs[bus.rd1_addr] : '0;

endmodule

`default_nettype wire

/* src/regfile_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface regfile_if;

    logic                   rd0_enable;
    regfile_pkg::reg_addr_t rd0_addr;
    regfile_pkg::reg_data_t rd0_data;

    logic                   rd1_enable;
    regfile_pkg::reg_addr_t rd1_addr;
    regfile_pkg::reg_data_t rd1_data;

    logic                   wr_enable;
    regfile_pkg::reg_addr_t wr_addr;
    regfile_pkg::reg_data_t wr_data;

    modport client (
        output rd0_enable, rd0_addr,
        output rd1_enable, rd1_addr,
        output wr_enable, wr_addr, wr_data,
        input  rd0_data, rd1_data
    );

    modport server (
        input  rd0_enable, rd0_addr,
        input  rd1_enable, rd1_addr,
        input  wr_enable, wr_addr, wr_data,
        output rd0_data, rd1_data
    );

endinterface

`default_nettype wire

/* src/regfile_pkg.sv */
`default_nettype none

package regfile_pkg;

    localparam int num_regs    = 8;
    localparam int cmd_depth   = 4;   // also the sender's starting credit count
    localparam int num_engines = 2;

    localparam int addr_width = $clog2(num_regs);
    localparam int data_width = 8;
    localparam int ptr_width  = $clog2(cmd_depth);

    typedef logic [addr_width-1:0] reg_addr_t;
    typedef logic [data_width-1:0] reg_data_t;
    typedef logic [ptr_width-1:0]  queue_ptr_t;
    typedef logic [ptr_width:0]    queue_count_t;   // 0 .. cmd_depth

    typedef enum logic [1:0] {
        op_write = 2'd0,
        op_read  = 2'd1,
        op_add   = 2'd2
    } cmd_op_t;

    // respond is the one-cycle bubble after a grant
    typedef enum logic [1:0] {
        idle,
        request,
        respond
    } engine_state_t;

endpackage

`default_nettype wire
